// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // Operation codes of the toy integer set
    typedef enum logic [2:0] {
        op_li  = 3'd0,
        op_add = 3'd1,
        op_sub = 3'd2,
        op_and = 3'd3,
        op_mul = 3'd4
    } op_t;

    // Architectural register index, eight registers
    typedef logic [2:0] reg_idx_t;

    // Data word
    typedef logic [15:0] word_t;

    // Station entry tag, zero means the value is already present
    typedef logic [2:0] rs_tag_t;

    // Decoded instruction as presented at dispatch
    typedef struct packed {
        op_t      op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        word_t    imm;
    } dispatch_t;

    // Source operand, either a value or the tag of its producer
    typedef struct packed {
        logic    ready;
        rs_tag_t tag;
        word_t   value;
    } operand_t;

    // Common data bus, one result per cycle
    typedef struct packed {
        logic     valid;
        rs_tag_t  tag;
        reg_idx_t dest;
        word_t    value;
    } cdb_t;

    // One issue slot towards the execute units
    typedef struct packed {
        logic     valid;
        rs_tag_t  tag;
        reg_idx_t dest;
        op_t      op;
        word_t    value_a;
        word_t    value_b;
    } issue_t;

    // Multiply class goes to the pipelined unit, all else to the ALU
    function automatic logic is_mul_op(input op_t op);
        return op == op_mul;
    endfunction

endpackage

`default_nettype wire

// ==== rename_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_table (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_strobe,
    input  logic               dispatch_accept,
    input  ooo_pkg::dispatch_t dispatch,
    input  ooo_pkg::rs_tag_t   alloc_tag,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::operand_t  operand_a,
    output ooo_pkg::operand_t  operand_b,
    input  ooo_pkg::reg_idx_t  read_index,
    output ooo_pkg::word_t     read_value
);
    import ooo_pkg::*;

    localparam int n_regs = 8;

    word_t   reg_values [n_regs];
    rs_tag_t reg_tags [n_regs];

    // Resolve one source, bypassing a result that is on the CDB right now
    function automatic operand_t lookup(input reg_idx_t index);
        operand_t result;
        result.ready = 1'b0;
        result.tag   = reg_tags[index];
        result.value = reg_values[index];
        if (reg_tags[index] == '0) begin
            result.ready = 1'b1;
        end else if (cdb.valid && cdb.tag == reg_tags[index]) begin
            result.ready = 1'b1;
            result.tag   = '0;
            result.value = cdb.value;
        end
        return result;
    endfunction

    always_comb begin
        operand_a = lookup(dispatch.src1);
        operand_b = lookup(dispatch.src2);
    end

    assign read_value = reg_values[read_index];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < n_regs; i++) begin
                reg_values[i] <= '0;
                reg_tags[i]   <= '0;
            end
        end else begin
            // Retire only if no younger writer has renamed the register since
            if (cdb.valid && reg_tags[cdb.dest] == cdb.tag) begin
                reg_values[cdb.dest] <= cdb.value;
                reg_tags[cdb.dest]   <= '0;
            end
            // Rename comes last so a new producer wins over a retiring one
            if (dispatch_strobe && dispatch_accept) begin
                reg_tags[dispatch.dest] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`timescale 1ns/10ps
`default_nettype none

module reservation_station #(
    parameter int alu_entries = 2,
    parameter int mul_entries = 2,
    parameter int mul_stages  = 3
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_strobe,
    input  ooo_pkg::dispatch_t     dispatch,
    input  ooo_pkg::operand_t      operand_a,
    input  ooo_pkg::operand_t      operand_b,
    input  ooo_pkg::cdb_t          cdb,
    output logic                   dispatch_accept,
    output ooo_pkg::rs_tag_t       alloc_tag,
    output ooo_pkg::issue_t [1:0]  issue
);
    import ooo_pkg::*;

    // Tags run 1..n_entries and must fit rs_tag_t, so at most 7 entries
    // ALU entries come first, multiply entries follow
    localparam int n_entries = alu_entries + mul_entries;

    typedef struct packed {
        logic     busy;
        logic     issued;
        op_t      op;
        reg_idx_t dest;
        operand_t a;
        operand_t b;
    } entry_t;

    entry_t               entries [n_entries];
    logic [n_entries-1:0] ready;
    logic                 dispatch_mul;
    operand_t             capture_a;
    operand_t             capture_b;
    issue_t               alu_pick;
    issue_t               mul_pick;
    logic                 alu_blocked;
    // Bit k set means a multiply issued k+1 edges ago
    logic [mul_stages-2:0] mul_history;

    function automatic rs_tag_t tag_of(input int index);
        return rs_tag_t'(index + 1);
    endfunction

    function automatic issue_t to_issue(input entry_t e, input int index);
        issue_t result;
        result.valid   = 1'b1;
        result.tag     = tag_of(index);
        result.dest    = e.dest;
        result.op      = e.op;
        result.value_a = e.a.value;
        result.value_b = e.b.value;
        return result;
    endfunction

    // Lowest free entry of the instruction's class, tag zero when full
    always_comb begin
        dispatch_mul = is_mul_op(dispatch.op);
        alloc_tag    = '0;
        for (int i = n_entries - 1; i >= 0; i--) begin
            if (!entries[i].busy && ((i >= alu_entries) == dispatch_mul)) begin
                alloc_tag = tag_of(i);
            end
        end
    end

    assign dispatch_accept = (alloc_tag != '0);

    // Load-immediate carries its value in imm, b is unused
    always_comb begin
        capture_a = operand_a;
        capture_b = operand_b;
        if (dispatch.op == op_li) begin
            capture_a = '{ready: 1'b1, tag: '0, value: dispatch.imm};
            capture_b = '{ready: 1'b1, tag: '0, value: '0};
        end
    end

    always_comb begin
        for (int i = 0; i < n_entries; i++) begin
            ready[i] = entries[i].busy && !entries[i].issued &&
                       entries[i].a.ready && entries[i].b.ready;
        end
    end

    // An ALU result issued now lands on the same edge as a multiply
    // issued mul_stages-1 edges back
    assign alu_blocked = mul_history[mul_stages-2];

    // Oldest-ready here means lowest tag within the class
    always_comb begin
        alu_pick = '0;
        mul_pick = '0;
        for (int i = alu_entries - 1; i >= 0; i--) begin
            if (ready[i] && !alu_blocked) begin
                alu_pick = to_issue(entries[i], i);
            end
        end
        for (int i = n_entries - 1; i >= alu_entries; i--) begin
            if (ready[i]) begin
                mul_pick = to_issue(entries[i], i);
            end
        end
    end

    // Slot 0 feeds the ALU, slot 1 the multiplier
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue       <= '0;
            mul_history <= '0;
        end else begin
            issue[0]       <= alu_pick;
            issue[1]       <= mul_pick;
            mul_history[0] <= mul_pick.valid;
            for (int k = 1; k < mul_stages - 1; k++) begin
                mul_history[k] <= mul_history[k-1];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < n_entries; i++) begin
                entries[i].busy   <= 1'b0;
                entries[i].issued <= 1'b0;
            end
        end else begin
            for (int i = 0; i < n_entries; i++) begin
                // Own result broadcast frees the entry
                if (cdb.valid && cdb.tag == tag_of(i)) begin
                    entries[i].busy   <= 1'b0;
                    entries[i].issued <= 1'b0;
                end
                if (alu_pick.tag == tag_of(i) || mul_pick.tag == tag_of(i)) begin
                    entries[i].issued <= 1'b1;
                end
                // Wakeup of waiting operands
                if (!entries[i].a.ready && cdb.valid && cdb.tag == entries[i].a.tag) begin
                    entries[i].a <= '{ready: 1'b1, tag: '0, value: cdb.value};
                end
                if (!entries[i].b.ready && cdb.valid && cdb.tag == entries[i].b.tag) begin
                    entries[i].b <= '{ready: 1'b1, tag: '0, value: cdb.value};
                end
                if (dispatch_strobe && alloc_tag == tag_of(i)) begin
                    entries[i] <= '{busy: 1'b1, issued: 1'b0, op: dispatch.op,
                                    dest: dispatch.dest, a: capture_a, b: capture_b};
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== execute_units.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_units #(
    parameter int mul_stages = 3
) (
    input  logic                  clock,
    input  logic                  reset,
    input  ooo_pkg::issue_t [1:0] issue,
    output ooo_pkg::cdb_t         cdb
);
    import ooo_pkg::*;

    word_t alu_result;
    word_t mul_product;
    // The CDB register is the last multiply stage
    cdb_t  mul_pipe [mul_stages-1];

    always_comb begin
        case (issue[0].op)
            op_li:   alu_result = issue[0].value_a;
            op_add:  alu_result = issue[0].value_a + issue[0].value_b;
            op_sub:  alu_result = issue[0].value_a - issue[0].value_b;
            op_and:  alu_result = issue[0].value_a & issue[0].value_b;
            default: alu_result = issue[0].value_a;
        endcase
    end

    // Low half of the product only
    assign mul_product = issue[1].value_a * issue[1].value_b;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < mul_stages - 1; k++) begin
                mul_pipe[k].valid <= 1'b0;
            end
        end else begin
            mul_pipe[0] <= '{valid: issue[1].valid, tag: issue[1].tag,
                             dest: issue[1].dest, value: mul_product};
            for (int k = 1; k < mul_stages - 1; k++) begin
                mul_pipe[k] <= mul_pipe[k-1];
            end
        end
    end

    // At most one of the two completes on a given edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cdb <= '0;
        end else if (mul_pipe[mul_stages-2].valid) begin
            cdb <= mul_pipe[mul_stages-2];
        end else if (issue[0].valid) begin
            cdb <= '{valid: 1'b1, tag: issue[0].tag, dest: issue[0].dest, value: alu_result};
        end else begin
            cdb <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core #(
    parameter int alu_entries = 2,
    parameter int mul_entries = 2,
    parameter int mul_stages  = 3
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch_strobe,
    input  ooo_pkg::dispatch_t dispatch,
    output logic               dispatch_accept,
    output ooo_pkg::cdb_t      cdb,
    input  ooo_pkg::reg_idx_t  read_index,
    output ooo_pkg::word_t     read_value
);
    import ooo_pkg::*;

    operand_t     operand_a;
    operand_t     operand_b;
    rs_tag_t      alloc_tag;
    issue_t [1:0] issue;

    rename_table i_rename_table (
        .clock           (clock),
        .reset           (reset),
        .dispatch_strobe (dispatch_strobe),
        .dispatch_accept (dispatch_accept),
        .dispatch        (dispatch),
        .alloc_tag       (alloc_tag),
        .cdb             (cdb),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .read_index      (read_index),
        .read_value      (read_value)
    );

    reservation_station #(
        .alu_entries (alu_entries),
        .mul_entries (mul_entries),
        .mul_stages  (mul_stages)
    ) i_reservation_station (
        .clock           (clock),
        .reset           (reset),
        .dispatch_strobe (dispatch_strobe),
        .dispatch        (dispatch),
        .operand_a       (operand_a),
        .operand_b       (operand_b),
        .cdb             (cdb),
        .dispatch_accept (dispatch_accept),
        .alloc_tag       (alloc_tag),
        .issue           (issue)
    );

    // Registered CDB loops back into the station and the rename table
    execute_units #(
        .mul_stages (mul_stages)
    ) i_execute_units (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

`default_nettype wire

// ==== ooo_core_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core_checker #(
    parameter int alu_entries = 2
) (
    input logic               clock,
    input logic               reset,
    input logic               dispatch_strobe,
    input logic               dispatch_accept,
    input ooo_pkg::dispatch_t dispatch,
    input ooo_pkg::rs_tag_t   alloc_tag,
    input ooo_pkg::operand_t  operand_a,
    input ooo_pkg::operand_t  operand_b,
    input ooo_pkg::issue_t    alu_pick,
    input ooo_pkg::issue_t    mul_pick,
    input ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    localparam rs_tag_t last_alu_tag = rs_tag_t'(alu_entries);

    // Shadow state is indexed by tag and entry 0 stays unused
    logic [7:0] busy_by_tag;
    logic [7:0] issued_by_tag;
    // Producer tag that each operand still waits for
    rs_tag_t    wait_a [8];
    rs_tag_t    wait_b [8];
    logic       class_match;

    assign class_match  = (dispatch.op == op_mul) ? (alloc_tag > last_alu_tag)
                                                  : (alloc_tag <= last_alu_tag);

    // Shadow occupancy is set on grant and pick and cleared by the broadcast
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_by_tag   <= '0;
            issued_by_tag <= '0;
        end else begin
            if (cdb.valid) begin
                busy_by_tag[cdb.tag]   <= 1'b0;
                issued_by_tag[cdb.tag] <= 1'b0;
            end
            if (alu_pick.valid) begin
                issued_by_tag[alu_pick.tag] <= 1'b1;
            end
            if (mul_pick.valid) begin
                issued_by_tag[mul_pick.tag] <= 1'b1;
            end
            if (dispatch_strobe && dispatch_accept) begin
                busy_by_tag[alloc_tag] <= 1'b1;
            end
        end
    end

    // Pending producers are taken at grant and dropped when they broadcast
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int t = 0; t < 8; t++) begin
                wait_a[t] <= '0;
                wait_b[t] <= '0;
            end
        end else begin
            for (int t = 0; t < 8; t++) begin
                if (cdb.valid && wait_a[t] == cdb.tag) begin
                    wait_a[t] <= '0;
                end
                if (cdb.valid && wait_b[t] == cdb.tag) begin
                    wait_b[t] <= '0;
                end
            end
            if (dispatch_strobe && dispatch_accept) begin
                wait_a[alloc_tag] <= (dispatch.op == op_li || operand_a.ready) ? '0
                                                                               : operand_a.tag;
                wait_b[alloc_tag] <= (dispatch.op == op_li || operand_b.ready) ? '0
                                                                               : operand_b.tag;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        dispatch_strobe && dispatch_accept |->
            !busy_by_tag[alloc_tag] && class_match)
        else $error("dispatch granted without a free entry of its class");

    assert property (@(posedge clock) disable iff (reset)
        alu_pick.valid |->
            wait_a[alu_pick.tag] == '0 && wait_b[alu_pick.tag] == '0 &&
            !issued_by_tag[alu_pick.tag])
        else $error("ALU pick has an operand pending or was already issued");

    assert property (@(posedge clock) disable iff (reset)
        mul_pick.valid |->
            wait_a[mul_pick.tag] == '0 && wait_b[mul_pick.tag] == '0 &&
            !issued_by_tag[mul_pick.tag])
        else $error("multiply pick has an operand pending or was already issued");

    assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb.tag != '0)
        else $error("CDB valid with tag zero");

endmodule

bind reservation_station ooo_core_checker #(
    .alu_entries (alu_entries)
) i_checker (
    .clock           (clock),
    .reset           (reset),
    .dispatch_strobe (dispatch_strobe),
    .dispatch_accept (dispatch_accept),
    .dispatch        (dispatch),
    .alloc_tag       (alloc_tag),
    .operand_a       (operand_a),
    .operand_b       (operand_b),
    .alu_pick        (alu_pick),
    .mul_pick        (mul_pick),
    .cdb             (cdb)
);

`default_nettype wire

// ==== ooo_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb;
    import ooo_pkg::*;

    localparam rs_tag_t last_alu_tag = 3'd2;

    logic      clock = 1'b0;
    logic      reset;
    logic      dispatch_strobe;
    dispatch_t dispatch;
    logic      dispatch_accept;
    cdb_t      cdb;
    reg_idx_t  read_index;
    word_t     read_value;

    // Program-order register model and per-tag scoreboard
    word_t       model [8];
    word_t       expected_value [8];
    reg_idx_t    expected_dest [8];
    int          sent [8];
    int          seen [8];
    int          broadcast_cycle [8];
    int          cycle_count;
    int          cdb_errors;
    int          check_errors;
    logic [31:0] lfsr_state;

    ooo_core #(
        .alu_entries (2),
        .mul_entries (2),
        .mul_stages  (3)
    ) i_dut (
        .clock           (clock),
        .reset           (reset),
        .dispatch_strobe (dispatch_strobe),
        .dispatch        (dispatch),
        .dispatch_accept (dispatch_accept),
        .cdb             (cdb),
        .read_index      (read_index),
        .read_value      (read_value)
    );

    always #5 clock = ~clock;

    // Arithmetic wraps at 16 bits and multiply keeps the low half
    function automatic word_t reference_result(input dispatch_t d);
        case (d.op)
            op_li:   return d.imm;
            op_add:  return model[d.src1] + model[d.src2];
            op_sub:  return model[d.src1] - model[d.src2];
            op_and:  return model[d.src1] & model[d.src2];
            default: return model[d.src1] * model[d.src2];
        endcase
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] result;
        result = '0;
        for (int k = 0; k < count; k++) begin
            result = {result[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
        end
        return result;
    endfunction

    function automatic dispatch_t build_instruction(input op_t op, input reg_idx_t dest,
                                                    input reg_idx_t src1, input reg_idx_t src2,
                                                    input word_t imm);
        dispatch_t d;
        d = '{op: op, dest: dest, src1: src1, src2: src2, imm: imm};
        return d;
    endfunction

    function automatic dispatch_t random_instruction();
        dispatch_t  d;
        logic [2:0] code;
        code   = 3'(random_bits(3));
        d.op   = (code > 3'd4) ? op_t'(code - 3'd4) : op_t'(code);
        d.dest = reg_idx_t'(random_bits(3));
        d.src1 = reg_idx_t'(random_bits(3));
        d.src2 = reg_idx_t'(random_bits(3));
        d.imm  = random_bits(16);
        return d;
    endfunction

    function automatic logic all_retired();
        for (int t = 1; t < 8; t++) begin
            if (sent[t] != seen[t]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic end_run();
        $display("errors: %0d on the CDB, %0d in dispatch and register checks",
                 cdb_errors, check_errors);
        if (cdb_errors == 0 && check_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        check_errors++;
        $display("%0t: timed out waiting for %s", $time, what);
        end_run();
    endtask

    // One cycle on the dispatch port with a grant entering the model at once
    task automatic present(input dispatch_t d, output logic accepted);
        rs_tag_t tag;
        logic    is_mul;
        @(posedge clock);
        dispatch_strobe <= 1'b1;
        dispatch        <= d;
        @(negedge clock);
        accepted = dispatch_accept;
        if (accepted) begin
            tag    = i_dut.alloc_tag;
            is_mul = (d.op == op_mul);
            if (is_mul != (tag > last_alu_tag)) begin
                check_errors++;
                $display("%0t: dispatch granted tag %0d outside its class", $time, tag);
            end
            if (sent[tag] != seen[tag]) begin
                check_errors++;
                $display("%0t: tag %0d handed out while still in flight", $time, tag);
            end
            expected_value[tag] = reference_result(d);
            expected_dest[tag]  = d.dest;
            model[d.dest]       = expected_value[tag];
            sent[tag]++;
        end
    endtask

    task automatic send(input dispatch_t d);
        logic accepted;
        int   tries;
        accepted = 1'b0;
        for (tries = 0; tries < 50 && !accepted; tries++) begin
            present(d, accepted);
        end
        if (!accepted) begin
            report_timeout("a dispatch to be accepted");
        end
    endtask

    task automatic drain();
        int cycles;
        @(posedge clock);
        dispatch_strobe <= 1'b0;
        for (cycles = 0; cycles < 200 && !all_retired(); cycles++) begin
            @(negedge clock);
        end
        if (!all_retired()) begin
            report_timeout("all results to be broadcast");
        end
    endtask

    task automatic check_registers();
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            dispatch_strobe <= 1'b0;
            read_index      <= reg_idx_t'(i);
            @(negedge clock);
            if (read_value !== model[i]) begin
                check_errors++;
                $display("[FAIL] %0t read_value r%0d: got %h expected %h",
                         $time, i, read_value, model[i]);
            end
        end
    endtask

    // Every broadcast must match the instruction that owns its tag
    always @(negedge clock) begin
        cycle_count++;
        if (!reset && cdb.valid) begin
            if (sent[cdb.tag] == seen[cdb.tag]) begin
                cdb_errors++;
                $display("%0t: CDB broadcast on tag %0d with nothing in flight", $time, cdb.tag);
            end else begin
                if (cdb.value !== expected_value[cdb.tag]) begin
                    cdb_errors++;
                    $display("[FAIL] %0t cdb.value tag %0d: got %h expected %h",
                             $time, cdb.tag, cdb.value, expected_value[cdb.tag]);
                end
                if (cdb.dest !== expected_dest[cdb.tag]) begin
                    cdb_errors++;
                    $display("[FAIL] %0t cdb.dest tag %0d: got %0d expected %0d",
                             $time, cdb.tag, cdb.dest, expected_dest[cdb.tag]);
                end
                seen[cdb.tag]++;
                broadcast_cycle[cdb.tag] = cycle_count;
            end
        end
    end

    initial begin
        logic accepted;
        reset           <= 1'b1;
        dispatch_strobe <= 1'b0;
        dispatch        <= '0;
        read_index      <= '0;
        lfsr_state = 32'h868e24bd;
        for (int i = 0; i < 8; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Reset state
        check_registers();

        // Immediates followed by dependent ALU chains
        send(build_instruction(op_li, 3'd1, 3'd0, 3'd0, 16'h1234));
        send(build_instruction(op_li, 3'd2, 3'd0, 3'd0, 16'h0f0f));
        send(build_instruction(op_li, 3'd3, 3'd0, 3'd0, 16'h0005));
        send(build_instruction(op_li, 3'd4, 3'd0, 3'd0, 16'hff00));
        send(build_instruction(op_add, 3'd5, 3'd1, 3'd2, '0));
        send(build_instruction(op_sub, 3'd6, 3'd5, 3'd3, '0));
        send(build_instruction(op_and, 3'd7, 3'd6, 3'd4, '0));
        send(build_instruction(op_add, 3'd5, 3'd7, 3'd5, '0));
        send(build_instruction(op_sub, 3'd1, 3'd1, 3'd5, '0));
        drain();
        check_registers();

        // Two multiplies in flight on the lowest free multiply tags 3 and 4
        send(build_instruction(op_mul, 3'd6, 3'd2, 3'd3, '0));
        send(build_instruction(op_mul, 3'd7, 3'd3, 3'd3, '0));
        send(build_instruction(op_add, 3'd0, 3'd1, 3'd2, '0));
        send(build_instruction(op_sub, 3'd4, 3'd2, 3'd3, '0));
        drain();
        if (broadcast_cycle[4] - broadcast_cycle[3] != 1) begin
            check_errors++;
            $display("%0t: back-to-back multiplies did not finish on consecutive cycles", $time);
        end
        send(build_instruction(op_mul, 3'd1, 3'd4, 3'd5, '0));
        send(build_instruction(op_add, 3'd2, 3'd1, 3'd3, '0));
        send(build_instruction(op_mul, 3'd3, 3'd3, 3'd2, '0));
        send(build_instruction(op_and, 3'd4, 3'd4, 3'd7, '0));
        send(build_instruction(op_li, 3'd5, 3'd0, 3'd0, 16'hbeef));
        send(build_instruction(op_mul, 3'd6, 3'd5, 3'd5, '0));
        send(build_instruction(op_sub, 3'd7, 3'd6, 3'd1, '0));
        drain();
        check_registers();

        // Slow writer then fast writer to the same register
        send(build_instruction(op_mul, 3'd2, 3'd3, 3'd4, '0));
        send(build_instruction(op_li, 3'd2, 3'd0, 3'd0, 16'h00a5));
        send(build_instruction(op_mul, 3'd6, 3'd6, 3'd1, '0));
        send(build_instruction(op_add, 3'd6, 3'd1, 3'd1, '0));
        drain();
        check_registers();

        // Both ALU entries wait on a multiply so a third ALU op must bounce
        send(build_instruction(op_mul, 3'd1, 3'd2, 3'd3, '0));
        send(build_instruction(op_add, 3'd4, 3'd1, 3'd1, '0));
        send(build_instruction(op_and, 3'd5, 3'd1, 3'd2, '0));
        present(build_instruction(op_sub, 3'd6, 3'd2, 3'd3, '0), accepted);
        if (accepted) begin
            check_errors++;
            $display("%0t: ALU dispatch accepted while both ALU entries were busy", $time);
        end
        present(build_instruction(op_mul, 3'd7, 3'd2, 3'd2, '0), accepted);
        if (!accepted) begin
            check_errors++;
            $display("%0t: multiply dispatch rejected while a multiply entry was free", $time);
        end
        send(build_instruction(op_sub, 3'd6, 3'd2, 3'd3, '0));
        drain();
        check_registers();

        // Random mix
        for (int n = 0; n < 200; n++) begin
            send(random_instruction());
        end
        drain();
        check_registers();

        end_run();
    end

endmodule

`default_nettype wire

// ==== all.f ====
ooo_pkg.sv
rename_table.sv
reservation_station.sv
execute_units.sv
ooo_core.sv
ooo_core_checker.sv
ooo_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the out-of-order core testbench

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= sim passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
